// ==== src/armCore_cfg.svh ====
`ifndef ARMCORE_CFG_SVH
`define ARMCORE_CFG_SVH

// Datapath sizes
`define DATA_W      32
`define REG_ADDR_W  4
`define NUM_REGS    16
`define INSTR_W     32

// Instruction fields
// Bit 25 picks the rotated immediate for operand B
`define IMM_BIT     25
`define OPC_HI      24
`define OPC_LO      21
`define RN_HI       19
`define RN_LO       16
`define RD_HI       15
`define RD_LO       12
// Rotate count, value is turned right by twice this
`define ROT_HI      11
`define ROT_LO      8
`define IMM8_HI     7
`define RM_HI       3

// Data-processing opcodes kept by the core
`define OP_AND  4'b0000
`define OP_EOR  4'b0001
`define OP_SUB  4'b0010
`define OP_RSB  4'b0011
`define OP_ADD  4'b0100
`define OP_ORR  4'b1100
`define OP_MOV  4'b1101
`define OP_BIC  4'b1110
`define OP_MVN  4'b1111

`endif

// ==== src/corePkg.sv ====
`include "armCore_cfg.svh"

package corePkg;

  typedef logic [`DATA_W-1:0]       wordT;     // One register or ALU word
  typedef logic [`REG_ADDR_W-1:0]   regAddrT;  // r0..r15
  typedef logic [`INSTR_W-1:0]      instrT;
  typedef logic [`OPC_HI-`OPC_LO:0] opcodeT;   // Bits 24:21 of the instruction

  // Decode to execute
  // Source indices travel along so execute can match them against writeback
  typedef struct packed {
    opcodeT  opcode;
    regAddrT rd;      // Destination
    regAddrT rn;      // Operand A source
    regAddrT rm;      // Operand B source when not immediate
    logic    useImm;  // Operand B came from the rotated immediate
    wordT    opA;     // Rn as read in decode
    wordT    opB;     // Rm read or rotated immediate
  } execBundleT;

  // Retired result, also the register file write
  typedef struct packed {
    regAddrT rd;
    wordT    data;
  } resultT;

endpackage

// ==== src/regFile.sv ====
`include "armCore_cfg.svh"

module regFile import corePkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regAddrT rnAddr,
  input  regAddrT rmAddr,
  output wordT    rnData,
  output wordT    rmData,
  input  logic    regWe,
  input  resultT  wrResult
);

  wordT regs [`NUM_REGS];  // All sixteen general purpose, no PC alias

  // Single write port, driven by the result handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (regWe) begin
      regs[wrResult.rd] <= wrResult.data;
    end
  end

  // Write-through on both read ports
  // Decode sees a result retiring in this same cycle
  assign rnData = (regWe && (wrResult.rd == rnAddr)) ? wrResult.data : regs[rnAddr];
  assign rmData = (regWe && (wrResult.rd == rmAddr)) ? wrResult.data : regs[rmAddr];

endmodule

// ==== src/decodeStage.sv ====
`include "armCore_cfg.svh"

module decodeStage import corePkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       advance,
  input  logic       inValid,
  input  instrT      inInstr,
  output regAddrT    rnAddr,
  output regAddrT    rmAddr,
  input  wordT       rnData,
  input  wordT       rmData,
  output logic       exValid,
  output execBundleT exBundle
);

  logic                     decValid;  // Decode register occupied
  instrT                    decInstr;
  opcodeT                   opcode;
  logic                     useImm;
  logic [`ROT_HI-`ROT_LO:0] rot;
  logic [`IMM8_HI:0]        imm8;
  wordT                     immZext;
  logic [2*`DATA_W-1:0]     immDbl;   // Two copies so a plain shift rotates
  wordT                     immRot;

  // Nine data-processing ops survive, the rest are dropped here
  function automatic logic opKnown(opcodeT op);
    case (op)
      `OP_AND, `OP_EOR, `OP_SUB, `OP_RSB, `OP_ADD,
      `OP_ORR, `OP_MOV, `OP_BIC, `OP_MVN: opKnown = 1'b1;
      default:                            opKnown = 1'b0;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      decValid <= 1'b0;
    end else if (advance) begin
      decValid <= inValid;  // Bubble when nothing offered
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      decInstr <= inInstr;
    end
  end

  // Field split
  assign opcode = decInstr[`OPC_HI:`OPC_LO];
  assign useImm = decInstr[`IMM_BIT];
  assign rot    = decInstr[`ROT_HI:`ROT_LO];
  assign imm8   = decInstr[`IMM8_HI:0];
  assign rnAddr = decInstr[`RN_HI:`RN_LO];
  assign rmAddr = decInstr[`RM_HI:0];  // Bits 11:4 unused, no shifter

  // ARM immediate, imm8 ROR (2*rot)
  assign immZext = {{(`DATA_W-`IMM8_HI-1){1'b0}}, imm8};
  assign immDbl  = {immZext, immZext} >> {rot, 1'b0};
  assign immRot  = immDbl[`DATA_W-1:0];

  assign exValid = decValid && opKnown(opcode);  // Unknown ops retire nothing

  always_comb begin
    exBundle.opcode = opcode;
    exBundle.rd     = decInstr[`RD_HI:`RD_LO];
    exBundle.rn     = rnAddr;
    exBundle.rm     = rmAddr;
    exBundle.useImm = useImm;
    exBundle.opA    = rnData;
    exBundle.opB    = useImm ? immRot : rmData;  // Operand B select
  end

  // A rotation only moves bits, so the immediate keeps the imm8 bit count
  aImmRotate: assert property (@(posedge clk) disable iff (rst)
    exValid && exBundle.useImm |-> $countones(exBundle.opB) == $countones(imm8))
    else $error("rotated immediate lost or gained bits, imm8 %h rot %0d", imm8, rot);

endmodule

// ==== src/execStage.sv ====
`include "armCore_cfg.svh"

module execStage import corePkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       advance,
  input  logic       exValid,
  input  execBundleT exBundle,
  input  logic       resValid,
  input  resultT     resData,
  output logic       wbInValid,
  output resultT     wbInResult
);

  logic       exRegValid;  // Execute register occupied
  execBundleT exReg;
  logic       fwdA;
  logic       fwdB;
  wordT       srcA;
  wordT       srcB;
  wordT       aluOut;

  always_ff @(posedge clk) begin
    if (rst) begin
      exRegValid <= 1'b0;
    end else if (advance) begin
      exRegValid <= exValid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      exReg <= exBundle;
    end
  end

  // Forwarding
  // The result waiting in writeback was still in execute when this
  // instruction read its sources, so the register file value is stale
  assign fwdA = resValid && (resData.rd == exReg.rn);
  assign fwdB = resValid && !exReg.useImm && (resData.rd == exReg.rm);  // Never over an imm

  assign srcA = fwdA ? resData.data : exReg.opA;
  assign srcB = fwdB ? resData.data : exReg.opB;

  // ALU, 32-bit wraparound, no flags
  always_comb begin
    case (exReg.opcode)
      `OP_AND: aluOut = srcA & srcB;
      `OP_EOR: aluOut = srcA ^ srcB;
      `OP_SUB: aluOut = srcA - srcB;
      `OP_RSB: aluOut = srcB - srcA;  // Reverse subtract
      `OP_ADD: aluOut = srcA + srcB;
      `OP_ORR: aluOut = srcA | srcB;
      `OP_MOV: aluOut = srcB;         // Rn not used
      `OP_BIC: aluOut = srcA & ~srcB;
      `OP_MVN: aluOut = ~srcB;
      default: aluOut = '0;           // Cannot reach, decode filters
    endcase
  end

  assign wbInValid       = exRegValid;
  assign wbInResult.rd   = exReg.rd;
  assign wbInResult.data = aluOut;

  // Catches payload that entered without a valid decode or reset-time X
  aResultKnown: assert property (@(posedge clk) disable iff (rst)
    wbInValid |-> !$isunknown(wbInResult))
    else $error("execute produced X/Z on a valid result");

endmodule

// ==== src/writebackStage.sv ====
module writebackStage import corePkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   wbInValid,
  input  resultT wbInResult,
  output logic   resValid,
  input  logic   resReady,
  output resultT resData,
  output logic   advance,
  output logic   regWe
);

  // Whole pipe moves when the result register is empty or being drained
  // An empty slot here lets bubbles behind it collapse
  assign advance = !resValid || resReady;

  // Register commit happens exactly on the output handshake
  assign regWe = resValid && resReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      resValid <= 1'b0;
    end else if (advance) begin
      resValid <= wbInValid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      resData <= wbInResult;  // Held under back-pressure
    end
  end

  // Output stays put while the consumer is stalling
  aHoldStable: assert property (@(posedge clk) disable iff (rst)
    resValid && !resReady |=> resValid && $stable(resData))
    else $error("result changed or dropped while stalled");

endmodule

// ==== src/pipeCore.sv ====
module pipeCore import corePkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   inValid,
  output logic   inReady,
  input  instrT  inInstr,
  output logic   resValid,
  input  logic   resReady,
  output resultT resData
);

  regAddrT    rnAddr;
  regAddrT    rmAddr;
  wordT       rnData;
  wordT       rmData;
  logic       exValid;
  execBundleT exBundle;
  logic       wbInValid;
  resultT     wbInResult;
  logic       advance;   // Single pipeline enable from writeback
  logic       regWe;

  assign inReady = advance;  // Accept whenever the pipe moves

  regFile uRegFile (
    .clk      (clk),
    .rst      (rst),
    .rnAddr   (rnAddr),
    .rmAddr   (rmAddr),
    .rnData   (rnData),
    .rmData   (rmData),
    .regWe    (regWe),
    .wrResult (resData)    // Retiring result doubles as write data
  );

  decodeStage uDecode (
    .clk      (clk),
    .rst      (rst),
    .advance  (advance),
    .inValid  (inValid),
    .inInstr  (inInstr),
    .rnAddr   (rnAddr),
    .rmAddr   (rmAddr),
    .rnData   (rnData),
    .rmData   (rmData),
    .exValid  (exValid),
    .exBundle (exBundle)
  );

  execStage uExec (
    .clk        (clk),
    .rst        (rst),
    .advance    (advance),
    .exValid    (exValid),
    .exBundle   (exBundle),
    .resValid   (resValid),   // Forwarding source
    .resData    (resData),
    .wbInValid  (wbInValid),
    .wbInResult (wbInResult)
  );

  writebackStage uWriteback (
    .clk        (clk),
    .rst        (rst),
    .wbInValid  (wbInValid),
    .wbInResult (wbInResult),
    .resValid   (resValid),
    .resReady   (resReady),
    .resData    (resData),
    .advance    (advance),
    .regWe      (regWe)
  );

endmodule

// ==== tb/coreTb.sv ====
`include "armCore_cfg.svh"

module coreTb import corePkg::*; ();

  localparam int numInstr   = 400;
  localparam int maxCycles  = numInstr * 10;  // Up to ten cycles per instruction
  localparam int drainLimit = 20;             // Three in flight empty well within this
  localparam opcodeT aluOps [9] = '{`OP_AND, `OP_EOR, `OP_SUB, `OP_RSB, `OP_ADD,
                                    `OP_ORR, `OP_MOV, `OP_BIC, `OP_MVN};

  logic   clk;
  logic   rst;
  logic   inValid;
  logic   inReady;
  instrT  inInstr;
  logic   resValid;
  logic   resReady;
  resultT resData;

  wordT    refRegs [`NUM_REGS];  // Register state in program order
  resultT  expQ [$];             // Results still owed by the DUT
  resultT  expRes;
  regAddrT lastRd;               // Reused often to stress forwarding
  logic    inputTaken;           // Handshake seen on the last rising edge

  int acceptCount;
  int validCount;
  int resultCount;
  int valueErrors;
  int endErrors;
  int resetErrors;
  int holdErrors;
  int readyErrors;
  int latencyErrors;

  pipeCore dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inInstr  (inInstr),
    .resValid (resValid),
    .resReady (resReady),
    .resData  (resData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic isAluOp(input opcodeT op);
    return op inside {`OP_AND, `OP_EOR, `OP_SUB, `OP_RSB, `OP_ADD,
                      `OP_ORR, `OP_MOV, `OP_BIC, `OP_MVN};
  endfunction

  // imm8 turned right by twice the rotate field
  function automatic wordT rotateImm(input logic [7:0] imm8, input logic [3:0] rot);
    wordT w;
    w = {24'd0, imm8};
    for (int i = 0; i < 2 * rot; i++) begin
      w = {w[0], w[31:1]};
    end
    return w;
  endfunction

  function automatic wordT aluResult(input opcodeT op, input wordT a, input wordT b);
    case (op)
      `OP_AND: return a & b;
      `OP_EOR: return a ^ b;
      `OP_SUB: return a - b;
      `OP_RSB: return b - a;
      `OP_ADD: return a + b;
      `OP_ORR: return a | b;
      `OP_MOV: return b;
      `OP_BIC: return a & ~b;
      default: return ~b;  // MVN, only caller filters the rest
    endcase
  endfunction

  function automatic int errorTotal();
    return valueErrors + endErrors + resetErrors + holdErrors + readyErrors + latencyErrors;
  endfunction

  // Random word first so the ignored bits and rotate field vary too
  task automatic makeInstr(output instrT instr);
    instrT   raw;
    regAddrT rn;
    regAddrT rm;
    regAddrT rd;
    raw = $urandom();
    if ($urandom_range(99) < 80) begin
      raw[`OPC_HI:`OPC_LO] = aluOps[$urandom_range(8)];
    end
    rn = ($urandom_range(99) < 50) ? lastRd : regAddrT'($urandom_range(15));
    rm = ($urandom_range(99) < 40) ? lastRd : regAddrT'($urandom_range(15));
    rd = ($urandom_range(99) < 30) ? lastRd : regAddrT'($urandom_range(15));
    raw[`RN_HI:`RN_LO] = rn;
    raw[`RD_HI:`RD_LO] = rd;
    if (!raw[`IMM_BIT]) begin
      raw[`RM_HI:0] = rm;  // Bits 11:4 stay random
    end
    lastRd = rd;
    instr  = raw;
  endtask

  // Expected result built at acceptance, registers committed in order
  task automatic modelAccept(input instrT instr);
    opcodeT op;
    wordT   a;
    wordT   b;
    resultT r;
    op = instr[`OPC_HI:`OPC_LO];
    if (isAluOp(op)) begin
      a = refRegs[instr[`RN_HI:`RN_LO]];
      if (instr[`IMM_BIT]) begin
        b = rotateImm(instr[`IMM8_HI:0], instr[`ROT_HI:`ROT_LO]);
      end else begin
        b = refRegs[instr[`RM_HI:0]];
      end
      r.rd   = instr[`RD_HI:`RD_LO];
      r.data = aluResult(op, a, b);
      expQ.push_back(r);
      refRegs[r.rd] = r.data;
      validCount++;
    end
  endtask

  task automatic reportCounts();
    $display("Accepted %0d, valid %0d, results %0d, value errors %0d, protocol errors %0d, %s %0d",
             acceptCount, validCount, resultCount, valueErrors,
             resetErrors + holdErrors + readyErrors + latencyErrors, "end errors", endErrors);
  endtask

  // Sampling on the rising edge, inputs were settled at the falling edge
  always @(posedge clk) begin
    if (rst) begin
      inputTaken = 1'b0;
    end else begin
      inputTaken = inValid && inReady;
      if (inputTaken) begin
        acceptCount++;
        modelAccept(inInstr);
      end
      if (resValid && resReady) begin
        resultCount++;
        if (expQ.size() == 0) begin
          valueErrors++;
          $display("Result for r%0d came out with no instruction outstanding", resData.rd);
        end else begin
          expRes = expQ.pop_front();
          assert (resData === expRes) else begin
            valueErrors++;
            $display("ERROR at %0t: got r%0d = %h, expected r%0d = %h",
                     $time, resData.rd, resData.data, expRes.rd, expRes.data);
          end
        end
      end
    end
  end

  resetState: assert property (@(posedge clk) $fell(rst) |-> !resValid && inReady)
    else begin
      resetErrors++;
      $display("Core not idle after reset, resValid or inReady wrong");
    end

  holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
    resValid && !resReady |=> resValid && $stable(resData))
    else begin
      holdErrors++;
      $display("Result dropped or changed while the consumer stalled");
    end

  readyLowWhileStalled: assert property (@(posedge clk) disable iff (rst)
    resValid && !resReady |-> !inReady)
    else begin
      readyErrors++;
      $display("Input accepted while the result port was stalled");
    end

  // Accept at k, pipe moving at k+1 and k+2, result visible at k+3
  fixedLatency: assert property (@(posedge clk) disable iff (rst)
    inValid && inReady && isAluOp(inInstr[`OPC_HI:`OPC_LO]) ##1 resReady ##1 resReady
    |=> resValid)
    else begin
      latencyErrors++;
      $display("Result did not appear three cycles after acceptance");
    end

  initial begin
    int n;
    n = 0;
    while (n < maxCycles) begin
      @(posedge clk);
      n++;
    end
    $display("Run stopped at the limit of %0d cycles, %0d results still owed",
             maxCycles, expQ.size());
    reportCounts();
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int drainWait;
    rst         = 1'b1;
    inValid     = 1'b0;
    inInstr     = '0;
    resReady    = 1'b1;
    lastRd      = '0;
    inputTaken  = 1'b0;
    acceptCount = 0;
    validCount  = 0;
    resultCount = 0;
    valueErrors = 0;
    endErrors   = 0;
    resetErrors = 0;
    holdErrors  = 0;
    readyErrors = 0;
    latencyErrors = 0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      refRegs[i] = '0;  // Matches the register file reset
    end
    void'($urandom(32'h7197_05c8));

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    do begin
      @(negedge clk);
      if (acceptCount >= numInstr / 2) begin
        resReady = ($urandom_range(99) >= 40);  // Back-pressure in the second half
      end else begin
        resReady = 1'b1;
      end
      if (!inValid || inputTaken) begin  // Otherwise hold the offered word
        if (acceptCount < numInstr && $urandom_range(9) != 0) begin
          inValid = 1'b1;
          makeInstr(inInstr);
        end else begin
          inValid = 1'b0;  // Bubble
        end
      end
    end while (acceptCount < numInstr);

    @(negedge clk);
    resReady = 1'b1;
    drainWait = 0;
    while (expQ.size() != 0 && drainWait < drainLimit) begin
      @(negedge clk);
      drainWait++;
    end
    repeat (4) @(negedge clk);  // Room for a stray extra result

    assert (expQ.size() == 0) else begin
      endErrors++;
      $display("Expected results left over at the end of the run");
    end
    assert (resultCount == validCount) else begin
      endErrors++;
      $display("Result count %0d differs from %0d valid instructions", resultCount, validCount);
    end
    assert (!resValid) else begin
      endErrors++;
      $display("Result still pending after the pipeline drained");
    end

    reportCounts();
    if (errorTotal() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/corePkg.sv
src/regFile.sv
src/decodeStage.sv
src/execStage.sv
src/writebackStage.sv
src/pipeCore.sv
tb/coreTb.sv
